/* source/dev_pkg.sv */
// --------------------
// device controller shared definitions
// baud divisors, frame layout and data widths
// for the command links and the power monitor
// --------------------

package dev_pkg;

    // --------------------
    // serial byte
    // --------------------
    localparam int byte_w         = 8;      // data bits per character

    // --------------------
    // link bit periods at 60 MHz
    // --------------------
    localparam int upc_baud_div   = 67;     // up-converter, no parity
    localparam int lc_baud_div    = 134;    // local pc, even parity
    localparam int rm_baud_div    = 67;     // remote pc, even parity
    localparam int pwr_baud_div   = 67;     // power sensor
    localparam int baud_cnt_w     = 16;     // bit period counter width

    // transmit side
    localparam int tx_queue_depth = 4;      // bytes incl. the one on the line

    // --------------------
    // power sensor frame
    // --------------------
    localparam logic [byte_w-1:0] pwr_header = 8'h5A;   // frame start
    localparam int pwr_word_w     = 16;     // one sensor word
    localparam int pwr_word_cnt   = 6;      // words per frame
    localparam int pwr_data_bytes = 12;     // payload, checksum excluded
    localparam int meas_w         = 32;     // published measurement

    // six sensor words, word k at [k]
    typedef logic [pwr_word_cnt-1:0][pwr_word_w-1:0] pwr_words_t;

endpackage

/* source/byte_stream_if.sv */
// --------------------
// received byte stream
// byte plus strobe and line status, no back-pressure
// --------------------
`timescale 1ns/1ps

interface byte_stream_if;

    logic [dev_pkg::byte_w-1:0] data;       // received character
    logic                       valid;      // one-cycle strobe
    logic                       parity_err; // parity mismatch
    logic                       stop_err;   // stop bit sampled low

    // receiver side
    modport rx   (output data, valid, parity_err, stop_err);

    // consumer must take the byte while valid is high
    modport sink (input  data, valid, parity_err, stop_err);

endinterface

/* source/uart_rx.sv */
// --------------------
// uart receiver
// two-flop sync, start edge detect, mid-bit sampling
// optional even parity check and bad-parity drop
// --------------------
`timescale 1ns/1ps

module uart_rx #(
    parameter int BAUD_DIV     = dev_pkg::upc_baud_div,
    parameter bit CHECK_EN     = 1'b0,
    parameter bit CHECK_FILTER = 1'b0
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        rx,                     // serial line
    byte_stream_if.rx   stream
);

    // index of the stop bit, start bit is index 0
    localparam int last_bit = CHECK_EN ? dev_pkg::byte_w + 2 : dev_pkg::byte_w + 1;

    logic [2:0]                     rx_ff;      // meta, sync, previous
    logic                           busy;
    logic [dev_pkg::baud_cnt_w-1:0] baud_cnt;
    logic [3:0]                     bit_idx;
    logic [dev_pkg::byte_w-1:0]     shift_reg;  // lsb first
    logic                           par_acc;    // running xor

    logic start_edge;
    logic mid_pt;
    logic bad_par;

    assign start_edge = rx_ff[2] & ~rx_ff[1];   // falling edge
    assign mid_pt     = busy && (baud_cnt == dev_pkg::baud_cnt_w'(BAUD_DIV / 2));
    assign bad_par    = CHECK_EN && par_acc;    // odd count of ones

    // --------------------
    // control and status
    // --------------------
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            rx_ff             <= 3'b111;        // line idles high
            busy              <= 1'b0;
            baud_cnt          <= '0;
            bit_idx           <= '0;
            par_acc           <= 1'b0;
            stream.valid      <= 1'b0;
            stream.parity_err <= 1'b0;
            stream.stop_err   <= 1'b0;
        end else begin
            rx_ff        <= {rx_ff[1:0], rx};
            stream.valid <= 1'b0;               // strobe default
            if (!busy) begin
                if (start_edge) begin
                    busy     <= 1'b1;
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    par_acc  <= 1'b0;
                end
            end else begin
                if (baud_cnt == dev_pkg::baud_cnt_w'(BAUD_DIV - 1)) begin
                    baud_cnt <= '0;
                    bit_idx  <= bit_idx + 4'd1;
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
                if (mid_pt) begin
                    if (bit_idx == 4'd0) begin
                        if (rx_ff[1]) busy <= 1'b0;     // glitch, not a start bit
                    end else if (bit_idx == 4'(last_bit)) begin
                        busy              <= 1'b0;      // rearm during stop bit
                        stream.parity_err <= bad_par;
                        stream.stop_err   <= ~rx_ff[1];
                        stream.valid      <= !(CHECK_FILTER && bad_par);
                    end else begin
                        par_acc <= par_acc ^ rx_ff[1];  // data and parity bits
                    end
                end
            end
        end
    end

    // payload path
    always_ff @(posedge clk_sys) begin
        if (mid_pt && bit_idx != 4'd0 && bit_idx <= 4'(dev_pkg::byte_w)) begin
            shift_reg <= {rx_ff[1], shift_reg[dev_pkg::byte_w-1:1]};
        end
        if (mid_pt && bit_idx == 4'(last_bit)) begin
            stream.data <= shift_reg;
        end
    end

    // --------------------
    // checks
    // --------------------
    a_valid_single : assert property (@(posedge clk_sys) disable iff (!rst_n)
        stream.valid |=> !stream.valid);

    a_bit_in_frame : assert property (@(posedge clk_sys) disable iff (!rst_n)
        busy |-> bit_idx <= 4'(last_bit));

endmodule

/* source/uart_tx.sv */
// --------------------
// uart transmitter
// small byte queue, start / data / even parity / stop
// writes into a full queue are dropped
// --------------------
`timescale 1ns/1ps

module uart_tx #(
    parameter int BAUD_DIV = dev_pkg::upc_baud_div,
    parameter bit CHECK_EN = 1'b0
) (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  logic                       tx_en,       // one cycle per byte
    input  logic [dev_pkg::byte_w-1:0] tx_data,
    output logic                       tx           // serial line
);

    localparam int frame_bits = CHECK_EN ? dev_pkg::byte_w + 3 : dev_pkg::byte_w + 2;
    localparam int ptr_w      = $clog2(dev_pkg::tx_queue_depth);
    localparam int fill_w     = $clog2(dev_pkg::tx_queue_depth + 1);

    logic [dev_pkg::byte_w-1:0] q_mem [dev_pkg::tx_queue_depth];
    logic [ptr_w-1:0]           wr_ptr;
    logic [ptr_w-1:0]           rd_ptr;
    logic [fill_w-1:0]          fill;           // waiting bytes
    logic                       busy;           // byte on the line
    logic [dev_pkg::baud_cnt_w-1:0] baud_cnt;
    logic [3:0]                 bit_cnt;        // bit now on the line
    logic [frame_bits-1:0]      shreg;          // remaining bits
    logic [frame_bits-1:0]      frame_next;

    logic baud_wrap, last_bit, push, pop;

    assign baud_wrap = baud_cnt == dev_pkg::baud_cnt_w'(BAUD_DIV - 1);
    assign last_bit  = bit_cnt == 4'(frame_bits - 1);
    // the byte on the line still holds a slot
    assign push = tx_en && (int'(fill) + int'(busy) < dev_pkg::tx_queue_depth);
    assign pop  = (fill != '0) && (!busy || (baud_wrap && last_bit));   // back to back

    always_comb begin
        frame_next                     = '1;    // stop bit
        frame_next[0]                  = 1'b0;  // start bit
        frame_next[dev_pkg::byte_w:1]  = q_mem[rd_ptr];
        if (CHECK_EN) frame_next[dev_pkg::byte_w+1] = ^q_mem[rd_ptr];  // even
    end

    // --------------------
    // queue and shifter control
    // --------------------
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            busy     <= 1'b0;
            tx       <= 1'b1;                   // idle high
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            fill <= fill + fill_w'(push) - fill_w'(pop);
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (pop) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
                tx       <= 1'b0;               // start bit
            end else if (busy) begin
                if (baud_wrap) begin
                    baud_cnt <= '0;
                    if (last_bit) begin
                        busy <= 1'b0;           // line already high
                    end else begin
                        tx      <= shreg[0];
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
        end
    end

    // storage and shift data
    always_ff @(posedge clk_sys) begin
        if (push) q_mem[wr_ptr] <= tx_data;
        if (pop) begin
            shreg <= {1'b1, frame_next[frame_bits-1:1]};
        end else if (busy && baud_wrap && !last_bit) begin
            shreg <= {1'b1, shreg[frame_bits-1:1]};
        end
    end

    a_fill_bound : assert property (@(posedge clk_sys) disable iff (!rst_n)
        int'(fill) <= dev_pkg::tx_queue_depth);

endmodule

/* source/pwr_monitor.sv */
// --------------------
// power sensor frame decoder
// header, 12 payload bytes, 8-bit sum checksum
// publishes interleaved voltage / current / power words
// --------------------
`timescale 1ns/1ps

module pwr_monitor (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    byte_stream_if.sink                stream,
    output logic [dev_pkg::meas_w-1:0] pwr_voltage,
    output logic [dev_pkg::meas_w-1:0] pwr_current,
    output logic [dev_pkg::meas_w-1:0] pwr_power,
    output logic                       pwr_valid     // one-cycle strobe
);

    localparam int idx_w = $clog2(dev_pkg::pwr_data_bytes);

    typedef enum logic [1:0] {
        st_idle,                                // hunting for header
        st_payload,                             // collecting words
        st_check                                // waiting for checksum
    } state_t;

    state_t                     state;
    logic [idx_w-1:0]           byte_idx;       // payload position
    logic [dev_pkg::byte_w-1:0] sum;            // low byte of payload sum
    logic                       frame_err;      // line error seen in frame
    dev_pkg::pwr_words_t        words;

    logic last_byte;
    logic frame_ok;
    logic line_err;

    assign last_byte = byte_idx == idx_w'(dev_pkg::pwr_data_bytes - 1);
    assign line_err  = stream.stop_err | stream.parity_err;
    assign frame_ok  = (stream.data == sum) && !frame_err && !line_err;

    // --------------------
    // frame fsm
    // --------------------
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state       <= st_idle;
            byte_idx    <= '0;
            sum         <= '0;
            frame_err   <= 1'b0;
            pwr_valid   <= 1'b0;
            pwr_voltage <= '0;
            pwr_current <= '0;
            pwr_power   <= '0;
        end else begin
            pwr_valid <= 1'b0;
            if (stream.valid) begin
                case (state)
                    st_idle: begin
                        if (stream.data == dev_pkg::pwr_header) begin
                            state     <= st_payload;
                            byte_idx  <= '0;
                            sum       <= '0;
                            frame_err <= line_err;  // header counts too
                        end
                    end
                    st_payload: begin
                        sum       <= sum + stream.data;
                        frame_err <= frame_err | line_err;
                        if (last_byte) state <= st_check;
                        else           byte_idx <= byte_idx + 1'b1;
                    end
                    st_check: begin
                        state <= st_idle;       // bad frame keeps old outputs
                        if (frame_ok) begin
                            pwr_valid   <= 1'b1;
                            pwr_voltage <= {words[3], words[0]};
                            pwr_current <= {words[4], words[1]};
                            pwr_power   <= {words[5], words[2]};
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // big-endian words, even byte is the high half
    always_ff @(posedge clk_sys) begin
        if (stream.valid && state == st_payload) begin
            if (byte_idx[0]) begin
                words[byte_idx[idx_w-1:1]][dev_pkg::byte_w-1:0] <= stream.data;
            end else begin
                words[byte_idx[idx_w-1:1]][dev_pkg::pwr_word_w-1:dev_pkg::byte_w]
                    <= stream.data;
            end
        end
    end

    a_idx_range : assert property (@(posedge clk_sys) disable iff (!rst_n)
        state == st_payload |-> int'(byte_idx) < dev_pkg::pwr_data_bytes);

endmodule

/* source/dev_top.sv */
// --------------------
// device controller serial side
// up-converter, local pc and remote pc command links
// plus the power sensor receiver
// --------------------
`timescale 1ns/1ps

module dev_top (
    input  logic                       clk_60m,
    input  logic                       rst_n,
    // --------------------
    // up-converter link
    input  logic                       upc_cfg_uart_rx,
    output logic                       upc_cfg_uart_tx,
    input  logic [dev_pkg::byte_w-1:0] upconvert_cfg_data,
    input  logic                       upconvert_cfg_data_valid,
    output logic [dev_pkg::byte_w-1:0] upconvert_rd_data,
    output logic                       upconvert_rd_data_valid,
    // --------------------
    // local pc link
    input  logic                       pc_lcuart_rx,
    output logic                       pc_lcuart_tx,
    input  logic                       pc_lctx_en,
    input  logic [dev_pkg::byte_w-1:0] pc_lctx_data,
    output logic [dev_pkg::byte_w-1:0] pc_lcrx_data,
    output logic                       pc_lcrx_data_valid,
    // --------------------
    // remote pc link
    input  logic                       pc_rmuart_rx,
    output logic                       pc_rmuart_tx,
    input  logic                       pc_rmtx_en,
    input  logic [dev_pkg::byte_w-1:0] pc_rmtx_data,
    output logic [dev_pkg::byte_w-1:0] pc_rmrx_data,
    output logic                       pc_rmrx_data_valid,
    // --------------------
    // power monitor
    input  logic                       pwr_uart_rx,
    output logic [dev_pkg::meas_w-1:0] pwr_voltage,
    output logic [dev_pkg::meas_w-1:0] pwr_current,
    output logic [dev_pkg::meas_w-1:0] pwr_power,
    output logic                       pwr_valid
);

    byte_stream_if upc_rx_if ();                // up-converter readback
    byte_stream_if lc_rx_if  ();                // local pc
    byte_stream_if rm_rx_if  ();                // remote pc
    byte_stream_if pwr_rx_if ();                // power sensor

    // up-converter, no parity
    uart_rx #(.BAUD_DIV(dev_pkg::upc_baud_div), .CHECK_EN(1'b0), .CHECK_FILTER(1'b0))
    u1_uart_rx (.clk_sys(clk_60m), .rst_n(rst_n), .rx(upc_cfg_uart_rx), .stream(upc_rx_if));
    uart_tx #(.BAUD_DIV(dev_pkg::upc_baud_div), .CHECK_EN(1'b0))
    u1_uart_tx (.clk_sys(clk_60m), .rst_n(rst_n), .tx_en(upconvert_cfg_data_valid),
                .tx_data(upconvert_cfg_data), .tx(upc_cfg_uart_tx));

    // local pc, even parity with drop
    uart_rx #(.BAUD_DIV(dev_pkg::lc_baud_div), .CHECK_EN(1'b1), .CHECK_FILTER(1'b1))
    u2_uart_rx (.clk_sys(clk_60m), .rst_n(rst_n), .rx(pc_lcuart_rx), .stream(lc_rx_if));
    uart_tx #(.BAUD_DIV(dev_pkg::lc_baud_div), .CHECK_EN(1'b1))
    u2_uart_tx (.clk_sys(clk_60m), .rst_n(rst_n), .tx_en(pc_lctx_en),
                .tx_data(pc_lctx_data), .tx(pc_lcuart_tx));

    // remote pc, even parity with drop
    uart_rx #(.BAUD_DIV(dev_pkg::rm_baud_div), .CHECK_EN(1'b1), .CHECK_FILTER(1'b1))
    u3_uart_rx (.clk_sys(clk_60m), .rst_n(rst_n), .rx(pc_rmuart_rx), .stream(rm_rx_if));
    uart_tx #(.BAUD_DIV(dev_pkg::rm_baud_div), .CHECK_EN(1'b1))
    u3_uart_tx (.clk_sys(clk_60m), .rst_n(rst_n), .tx_en(pc_rmtx_en),
                .tx_data(pc_rmtx_data), .tx(pc_rmuart_tx));

    // --------------------
    // power sensor path
    // --------------------
    uart_rx #(.BAUD_DIV(dev_pkg::pwr_baud_div), .CHECK_EN(1'b0), .CHECK_FILTER(1'b0))
    u4_uart_rx (.clk_sys(clk_60m), .rst_n(rst_n), .rx(pwr_uart_rx), .stream(pwr_rx_if));

    pwr_monitor u_pwr_monitor (
        .clk_sys     (clk_60m    ),             // (input )
        .rst_n       (rst_n      ),             // (input )
        .stream      (pwr_rx_if  ),             // (sink  )
        .pwr_voltage (pwr_voltage),             // (output) word 3 : word 0
        .pwr_current (pwr_current),             // (output) word 4 : word 1
        .pwr_power   (pwr_power  ),             // (output) word 5 : word 2
        .pwr_valid   (pwr_valid  )              // (output)
    );

    // received bytes out to the user
    assign upconvert_rd_data       = upc_rx_if.data;
    assign upconvert_rd_data_valid = upc_rx_if.valid;
    assign pc_lcrx_data            = lc_rx_if.data;
    assign pc_lcrx_data_valid      = lc_rx_if.valid;
    assign pc_rmrx_data            = rm_rx_if.data;
    assign pc_rmrx_data_valid      = rm_rx_if.valid;

endmodule

/* verif/dev_checker.sv */
// --------------------
// scoreboard for the serial side
// matches received bytes and power measurements
// against the expectations queued by the testbench
// --------------------
`timescale 1ns/1ps

module dev_checker (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    // dut outputs
    input  logic [dev_pkg::byte_w-1:0] upc_data,
    input  logic                       upc_valid,
    input  logic [dev_pkg::byte_w-1:0] lc_data,
    input  logic                       lc_valid,
    input  logic [dev_pkg::byte_w-1:0] rm_data,
    input  logic                       rm_valid,
    input  logic [dev_pkg::meas_w-1:0] pwr_voltage,
    input  logic [dev_pkg::meas_w-1:0] pwr_current,
    input  logic [dev_pkg::meas_w-1:0] pwr_power,
    input  logic                       pwr_valid,
    // expectations from the testbench
    input  logic [7:0]                 test_id,
    input  logic [7:0]                 test_kind,
    input  logic                       exp_push,    // one expected strobe
    input  logic [dev_pkg::byte_w-1:0] exp_byte,
    input  logic [dev_pkg::meas_w-1:0] exp_v,
    input  logic [dev_pkg::meas_w-1:0] exp_c,
    input  logic [dev_pkg::meas_w-1:0] exp_p,
    input  logic                       test_end,
    input  logic                       report,
    output int                         pending,     // strobes still owed
    output int                         err_total
);

    logic [dev_pkg::byte_w-1:0] q_upc [$];
    logic [dev_pkg::byte_w-1:0] q_lc  [$];
    logic [dev_pkg::byte_w-1:0] q_rm  [$];
    int pwr_due;                                // good frames owed
    int n_mismatch, n_missing, n_extra;

    assign err_total = n_mismatch + n_missing + n_extra;

    function automatic string test_name(input logic [7:0] kind);
        case (kind)
            8'd1:    return "upc_loopback";
            8'd2:    return "lc_loopback";
            8'd3:    return "rm_loopback";
            8'd4:    return "tx_overflow";
            8'd5:    return "parity_filter";
            8'd6:    return "pwr_frame";
            default: return "no_test";
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            n_mismatch++;
            $display("FAIL %s #%0h %s: expected %0h actual %0h",
                     test_name(test_kind), test_id, what, exp, act);
        end
    endtask

    task automatic unexpected(input string link, input logic [31:0] act);
        n_extra++;
        $display("test %s #%0h: value %0h showed up on the %s link with nothing expected",
                 test_name(test_kind), test_id, act, link);
    endtask

    task automatic missing(input string link, input int n);
        if (n != 0) begin
            n_missing += n;
            $display("test %s #%0h: %0d expected strobe(s) on the %s link never came",
                     test_name(test_kind), test_id, n, link);
        end
    endtask

    // --------------------
    // compare on every strobe
    // --------------------
    always @(posedge clk_sys) begin
        if (!rst_n) begin
            q_upc.delete();
            q_lc.delete();
            q_rm.delete();
            pwr_due    = 0;
            n_mismatch = 0;
            n_missing  = 0;
            n_extra    = 0;
        end else begin
            if (exp_push) begin
                case (test_kind)
                    8'd1, 8'd4: q_upc.push_back(exp_byte);     // up-converter
                    8'd2:       q_lc.push_back(exp_byte);
                    8'd3, 8'd5: q_rm.push_back(exp_byte);      // remote pc
                    8'd6:       pwr_due++;
                    default:    ;
                endcase
            end
            if (upc_valid) begin
                if (q_upc.size() == 0) unexpected("up-converter", 32'(upc_data));
                else compare("up-converter byte", 32'(q_upc.pop_front()), 32'(upc_data));
            end
            if (lc_valid) begin
                if (q_lc.size() == 0) unexpected("local pc", 32'(lc_data));
                else compare("local pc byte", 32'(q_lc.pop_front()), 32'(lc_data));
            end
            if (rm_valid) begin
                if (q_rm.size() == 0) unexpected("remote pc", 32'(rm_data));
                else compare("remote pc byte", 32'(q_rm.pop_front()), 32'(rm_data));
            end
            if (pwr_valid) begin
                if (pwr_due == 0) begin
                    unexpected("power", pwr_voltage);
                end else begin
                    pwr_due--;
                    compare("pwr_voltage", exp_v, pwr_voltage);
                    compare("pwr_current", exp_c, pwr_current);
                    compare("pwr_power", exp_p, pwr_power);
                end
            end
            if (test_end) begin
                missing("up-converter", q_upc.size());
                missing("local pc", q_lc.size());
                missing("remote pc", q_rm.size());
                missing("power", pwr_due);
                q_upc.delete();
                q_lc.delete();
                q_rm.delete();
                pwr_due = 0;
                if (test_kind == 8'd6) begin        // outputs hold after a bad frame
                    compare("held pwr_voltage", exp_v, pwr_voltage);
                    compare("held pwr_current", exp_c, pwr_current);
                    compare("held pwr_power", exp_p, pwr_power);
                end
            end
            if (report) begin
                $display("errors: %0d mismatched, %0d missing, %0d unexpected",
                         n_mismatch, n_missing, n_extra);
            end
        end
        pending <= q_upc.size() + q_lc.size() + q_rm.size() + pwr_due;
    end

endmodule

/* verif/tb_dev_top.sv */
// --------------------
// testbench for the device controller serial side
// loops each command link back on itself, drives the remote
// and power lines from a serializer, reads tests from a vector file
// --------------------
`timescale 1ns/1ps

module tb_dev_top;

    localparam int n_fields  = 22;              // values per vector line
    localparam int max_tests = 32;

    logic clk_60m;
    logic rst_n;
    logic upc_en, lc_en, rm_en;                 // transmit strobes
    logic [dev_pkg::byte_w-1:0] tx_byte;        // shared transmit data
    logic rm_drive_en;                          // serializer owns remote rx
    logic rm_line, pwr_line;
    logic upc_tx, lc_tx, rm_tx, rm_rx;
    logic [dev_pkg::byte_w-1:0] upc_rd, lc_rd, rm_rd;
    logic upc_rd_v, lc_rd_v, rm_rd_v;
    logic [dev_pkg::meas_w-1:0] pwr_voltage, pwr_current, pwr_power;
    logic pwr_valid;
    // checker control
    logic [7:0] test_id, test_kind;
    logic exp_push, test_end, report;
    logic [dev_pkg::byte_w-1:0] exp_byte;
    logic [dev_pkg::meas_w-1:0] exp_v, exp_c, exp_p;
    int pending, err_total;
    logic [31:0] vec [0:n_fields*max_tests-1];
    int cycles = 0;
    int limit  = 0;

    assign rm_rx = rm_drive_en ? rm_line : rm_tx;   // loopback unless driven

    dev_top dut_i (
        .clk_60m(clk_60m), .rst_n(rst_n),
        .upc_cfg_uart_rx(upc_tx), .upc_cfg_uart_tx(upc_tx),
        .upconvert_cfg_data(tx_byte), .upconvert_cfg_data_valid(upc_en),
        .upconvert_rd_data(upc_rd), .upconvert_rd_data_valid(upc_rd_v),
        .pc_lcuart_rx(lc_tx), .pc_lcuart_tx(lc_tx),
        .pc_lctx_en(lc_en), .pc_lctx_data(tx_byte),
        .pc_lcrx_data(lc_rd), .pc_lcrx_data_valid(lc_rd_v),
        .pc_rmuart_rx(rm_rx), .pc_rmuart_tx(rm_tx),
        .pc_rmtx_en(rm_en), .pc_rmtx_data(tx_byte),
        .pc_rmrx_data(rm_rd), .pc_rmrx_data_valid(rm_rd_v),
        .pwr_uart_rx(pwr_line), .pwr_voltage(pwr_voltage), .pwr_current(pwr_current),
        .pwr_power(pwr_power), .pwr_valid(pwr_valid)
    );

    dev_checker chk_i (
        .clk_sys(clk_60m), .rst_n(rst_n),
        .upc_data(upc_rd), .upc_valid(upc_rd_v), .lc_data(lc_rd), .lc_valid(lc_rd_v),
        .rm_data(rm_rd), .rm_valid(rm_rd_v), .pwr_voltage(pwr_voltage),
        .pwr_current(pwr_current), .pwr_power(pwr_power), .pwr_valid(pwr_valid),
        .test_id(test_id), .test_kind(test_kind), .exp_push(exp_push), .exp_byte(exp_byte),
        .exp_v(exp_v), .exp_c(exp_c), .exp_p(exp_p), .test_end(test_end),
        .report(report), .pending(pending), .err_total(err_total)
    );

    initial begin
        clk_60m = 1'b0;
        forever #50 clk_60m = ~clk_60m;        // 100 ns period
    end

    // run guard
    always @(posedge clk_60m) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    // --------------------
    // stimulus helpers
    // --------------------
    task automatic send_serial(input bit to_pwr, input logic [7:0] b, input bit has_par,
                               input bit par, input int div);
        logic [10:0] frame;
        int n_bits;
        frame  = has_par ? {1'b1, par, b, 1'b0} : {2'b11, b, 1'b0};    // lsb goes first
        n_bits = has_par ? 11 : 10;
        for (int i = 0; i < n_bits; i++) begin
            @(posedge clk_60m);
            #1;
            if (to_pwr) pwr_line = frame[i];
            else        rm_line  = frame[i];
            repeat (div - 1) @(posedge clk_60m);
        end
    endtask

    // one strobe per cycle into the kind's transmitter
    task automatic strobe_bytes(input logic [7:0] kind, input int base, input int n);
        for (int i = 0; i < n; i++) begin
            tx_byte = vec[base+i][7:0];
            upc_en  = (kind == 8'd1) || (kind == 8'd4);
            lc_en   = (kind == 8'd2);
            rm_en   = (kind == 8'd3);
            @(posedge clk_60m);
            #1;
        end
        upc_en = 1'b0;
        lc_en  = 1'b0;
        rm_en  = 1'b0;
    endtask

    task automatic run_test(input int t);
        int base, n_send, n_exp, first;
        logic [7:0] kind, b;
        base   = t * n_fields;
        kind   = vec[base+1][7:0];
        n_send = int'(vec[base+2]);
        n_exp  = int'(vec[base+3]);
        first  = int'(vec[base+4]);                 // bad bytes ahead of good ones
        @(posedge clk_60m);
        #1;
        test_id     = vec[base][7:0];
        test_kind   = kind;
        exp_v       = vec[base+19];
        exp_c       = vec[base+20];
        exp_p       = vec[base+21];
        rm_drive_en = (kind == 8'd5);
        for (int i = 0; i < n_exp; i++) begin
            exp_push = 1'b1;
            exp_byte = vec[base+5+first+i][7:0];
            @(posedge clk_60m);
            #1;
        end
        exp_push = 1'b0;
        case (kind)
            8'd1, 8'd2, 8'd3, 8'd4: strobe_bytes(kind, base + 5, n_send);
            8'd5: begin
                for (int i = 0; i < n_send; i++) begin
                    b = vec[base+5+i][7:0];
                    send_serial(1'b0, b, 1'b1, (i < first) ? ~^b : ^b, dev_pkg::rm_baud_div);
                end
            end
            8'd6: begin
                b = 8'($urandom());                 // idle noise ahead of the frame
                if (b == dev_pkg::pwr_header) b = b ^ 8'h01;
                send_serial(1'b1, b, 1'b0, 1'b0, dev_pkg::pwr_baud_div);
                for (int i = 0; i < n_send; i++) begin
                    send_serial(1'b1, vec[base+5+i][7:0], 1'b0, 1'b0, dev_pkg::pwr_baud_div);
                end
            end
            default: ;
        endcase
        do begin
            @(posedge clk_60m);
            #1;
        end while (pending != 0);
        repeat (11 * dev_pkg::lc_baud_div) @(posedge clk_60m);    // one slow frame quiet
        #1;
        test_end = 1'b1;
        @(posedge clk_60m);
        #1;
        test_end    = 1'b0;
        rm_drive_en = 1'b0;
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int n_tests;
        void'($urandom(32'h8e3b));
        rst_n = 1'b0;
        upc_en = 1'b0;
        lc_en = 1'b0;
        rm_en = 1'b0;
        tx_byte = '0;
        rm_drive_en = 1'b0;
        rm_line = 1'b1;                             // lines idle high
        pwr_line = 1'b1;
        test_id = '0;
        test_kind = '0;
        exp_push = 1'b0;
        exp_byte = '0;
        exp_v = '0;
        exp_c = '0;
        exp_p = '0;
        test_end = 1'b0;
        report = 1'b0;
        for (int i = 0; i < n_fields * max_tests; i++) vec[i] = '0;
        $readmemh("verif/dev_vectors.txt", vec);
        n_tests = 0;
        while (n_tests < max_tests && vec[n_tests*n_fields+1] != 0) n_tests++;
        limit = n_tests * 16 * 11 * dev_pkg::lc_baud_div;
        repeat (5) @(posedge clk_60m);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < n_tests; t++) run_test(t);
        report = 1'b1;
        @(posedge clk_60m);
        #1;
        report = 1'b0;
        @(posedge clk_60m);
        #1;
        if (err_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verif/dev_vectors.txt */
// id kind n_send n_exp first | 14 bytes | exp_voltage exp_current exp_power
// kind 1 upc loopback, 2 lc loopback, 3 rm loopback, 4 tx overflow on upc,
// 5 parity filter on rm (first = bad-parity bytes), 6 power frame (n_exp = pwr_valid)
01 1 04 04 00  00 FF A5 3C 00 00 00 00 00 00 00 00 00 00  0 0 0
02 1 03 03 00  81 7E 10 00 00 00 00 00 00 00 00 00 00 00  0 0 0
03 2 04 04 00  55 AA 01 80 00 00 00 00 00 00 00 00 00 00  0 0 0
04 2 02 02 00  C3 96 00 00 00 00 00 00 00 00 00 00 00 00  0 0 0
05 3 04 04 00  12 34 56 78 00 00 00 00 00 00 00 00 00 00  0 0 0
06 3 01 01 00  E7 00 00 00 00 00 00 00 00 00 00 00 00 00  0 0 0
07 3 04 04 00  00 FF 5A C3 00 00 00 00 00 00 00 00 00 00  0 0 0
08 4 05 04 00  11 22 33 44 55 00 00 00 00 00 00 00 00 00  0 0 0
09 5 02 01 01  3C A7 00 00 00 00 00 00 00 00 00 00 00 00  0 0 0
0A 5 02 01 01  55 55 00 00 00 00 00 00 00 00 00 00 00 00  0 0 0
0B 5 03 01 02  01 FE 80 00 00 00 00 00 00 00 00 00 00 00  0 0 0
0C 6 0E 01 00  5A 12 34 56 78 9A BC 01 02 03 04 05 06 7F  01021234 03045678 05069ABC
0D 6 0E 00 00  5A 11 22 33 44 55 66 77 88 99 AA BB CC 2F  01021234 03045678 05069ABC
0E 6 0E 01 00  5A A0 A1 B0 B1 C0 C1 D0 D1 E0 E1 F0 F1 66  D0D1A0A1 E0E1B0B1 F0F1C0C1

/* sim.f */
source/dev_pkg.sv
source/byte_stream_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/pwr_monitor.sv
source/dev_top.sv
verif/dev_checker.sv
verif/tb_dev_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dev_top
RTL_TOP   ?= dev_top
SEED      ?= 1
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
